/* design/glue_pkg.sv */
// shared address map, reset timing and type definitions for the system glue; import with glue_pkg::*
`default_nettype none

package glue_pkg;

	// --------------------
	// bus widths
	// --------------------
	localparam int ADDR_W = 23; // word address, cpu a23..a1
	localparam int DATA_W = 16;

	// --------------------
	// address map
	// --------------------
	// all values are word addresses, i.e. the byte address shifted right by one
	localparam int unsigned RAM_BLOCK_WORDS = 32'h0004_0000; // one 512 KB ram step
	localparam int unsigned PAGE_WORDS      = 32'h0000_8000; // one 64 KB page
	localparam int unsigned CHIP_BASE       = 32'h0000_0000; // byte $000000
	localparam int unsigned SLOW_BASE       = 32'h0060_0000; // byte $c00000, up to 1.5 MB
	localparam int unsigned ROM_BASE        = 32'h007c_0000; // byte $f80000, 512 KB kickstart
	localparam int unsigned CIA_BASE        = 32'h005f_8000; // byte $bf0000
	localparam int unsigned CUSTOM_BASE     = 32'h006f_8000; // byte $df0000
	localparam int unsigned RTC_BASE        = 32'h006e_0000; // byte $dc0000
	localparam int unsigned OVL_LIMIT       = 32'h0004_0000; // byte $080000, kick mirror at 0

	// --------------------
	// reset sequencing
	// --------------------
	localparam int RESET_FRAMES = 4; // frame starts to wait after the last request
	localparam int FRAME_CNT_W  = $clog2(RESET_FRAMES + 1);

	// configuration field widths from the host mcu
	localparam int MEMCFG_W  = 7; // [1:0] chip size, [3:2] slow size
	localparam int CHIPCFG_W = 5; // [1] ntsc, [4] aga
	localparam int CPUCFG_W  = 4; // [2] fast chip, [3] fast kick

	// --------------------
	// types
	// --------------------
	typedef enum logic [2:0] {
		RGN_NONE,   // unmapped, reads back zero
		RGN_CHIP,
		RGN_SLOW,
		RGN_ROM,
		RGN_CIA_A,
		RGN_CIA_B,
		RGN_CUSTOM,
		RGN_RTC
	} region_e;

	typedef enum logic [1:0] {
		CYC_IDLE,
		CYC_READ,
		CYC_WRITE
	} cycle_e;

	// external sram bank select
	typedef enum logic [1:0] {
		BANK_CHIP,
		BANK_SLOW,
		BANK_ROM
	} bank_e;

endpackage

`default_nettype wire

/* design/bus_decode.sv */
// cpu address decoder; maps each strobed access to a target region and a cycle type
`timescale 1ns/1ps
`default_nettype none

module bus_decode import glue_pkg::*; (
	input  logic            cpu_as_i,    // one-cycle access strobe
	input  logic            cpu_rw_i,    // 1 = read
	input  logic [ADDR_W:1] cpu_addr_i,  // bit n is byte address bit n
	input  logic            ovl_i,       // kickstart overlay at address 0
	input  logic [1:0]      chip_size_i, // (code + 1) x 512 KB
	input  logic [1:0]      slow_size_i, // code x 512 KB, 0 = none
	output region_e         region_o,
	output cycle_e          cycle_o
);

	logic [31:0] word_addr; // zero extended for range compares
	logic [31:0] chip_top;
	logic [31:0] slow_top;
	region_e     region;

	// base <= addr < base + words
	function automatic logic in_window(input logic [31:0] addr, input logic [31:0] base,
		input logic [31:0] words);
		in_window = (addr >= base) && (addr < base + words);
	endfunction

	// --------------------
	// region decode
	// --------------------
	always_comb begin
		word_addr = 32'(cpu_addr_i);
		chip_top  = (32'(chip_size_i) + 32'd1) * RAM_BLOCK_WORDS; // size of chip window
		slow_top  = 32'(slow_size_i) * RAM_BLOCK_WORDS;          // zero size when no slow ram

		region = RGN_NONE;
		if (in_window(word_addr, ROM_BASE, RAM_BLOCK_WORDS)) begin
			region = RGN_ROM;
		end else if (in_window(word_addr, CHIP_BASE, chip_top)) begin
			// overlay mirrors the rom over low chip ram for reads only
			if (ovl_i && cpu_rw_i && word_addr < OVL_LIMIT)
				region = RGN_ROM;
			else
				region = RGN_CHIP;
		end else if (in_window(word_addr, SLOW_BASE, slow_top)) begin
			region = RGN_SLOW;
		end else if (in_window(word_addr, CIA_BASE, PAGE_WORDS)) begin
			if (!cpu_addr_i[12])
				region = RGN_CIA_A; // $bfe001 style, a12 low
			else if (!cpu_addr_i[13])
				region = RGN_CIA_B; // $bfd000 style, a13 low
		end else if (in_window(word_addr, CUSTOM_BASE, PAGE_WORDS)) begin
			region = RGN_CUSTOM;
		end else if (in_window(word_addr, RTC_BASE, PAGE_WORDS)) begin
			region = RGN_RTC;
		end
	end

	// --------------------
	// cycle type
	// --------------------
	always_comb begin
		if (!cpu_as_i) begin
			cycle_o  = CYC_IDLE;
			region_o = RGN_NONE; // nothing selected without a strobe
		end else begin
			cycle_o  = cpu_rw_i ? CYC_READ : CYC_WRITE;
			region_o = region;
		end
	end

endmodule

`default_nettype wire

/* design/bus_execute.sv */
// access stage; registers a decoded cpu access and fires the target strobes one cycle later
`timescale 1ns/1ps
`default_nettype none

module bus_execute import glue_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  region_e           region_i,
	input  cycle_e            cycle_i,
	input  logic [ADDR_W:1]   cpu_addr_i,
	input  logic [DATA_W-1:0] cpu_wdata_i,
	input  logic              cpu_uds_n_i, // upper byte, d15..d8
	input  logic              cpu_lds_n_i, // lower byte, d7..d0
	output logic              ram_rd_o,
	output logic              ram_hwr_o,
	output logic              ram_lwr_o,
	output bank_e             ram_bank_o,
	output logic [ADDR_W:1]   ram_addr_o,
	output logic [DATA_W-1:0] ram_wdata_o,
	output logic              cia_a_sel_o,
	output logic              cia_b_sel_o,
	output logic              custom_sel_o,
	output logic              cpu_wr_o,     // registered access is a write
	output region_e           acc_region_o, // tells the merge stage who answers
	output logic              acc_valid_o
);

	logic active;   // strobed access this cycle
	logic is_write;
	logic mem_rd;   // ram or rom read
	logic ram_wr;   // chip or slow write, rom writes fall out here

	always_comb begin
		active   = (cycle_i != CYC_IDLE);
		is_write = (cycle_i == CYC_WRITE);
		mem_rd   = (cycle_i == CYC_READ) &&
			(region_i == RGN_CHIP || region_i == RGN_SLOW || region_i == RGN_ROM);
		ram_wr   = is_write && (region_i == RGN_CHIP || region_i == RGN_SLOW);
	end

	// --------------------
	// strobes and control
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			acc_valid_o  <= 1'b0;
			acc_region_o <= RGN_NONE;
			cpu_wr_o     <= 1'b0;
			ram_rd_o     <= 1'b0;
			ram_hwr_o    <= 1'b0;
			ram_lwr_o    <= 1'b0;
			cia_a_sel_o  <= 1'b0;
			cia_b_sel_o  <= 1'b0;
			custom_sel_o <= 1'b0;
		end else begin
			acc_valid_o  <= active; // every access gets a dtack, mapped or not
			acc_region_o <= region_i;
			cpu_wr_o     <= is_write;
			ram_rd_o     <= mem_rd;
			ram_hwr_o    <= ram_wr && !cpu_uds_n_i;
			ram_lwr_o    <= ram_wr && !cpu_lds_n_i;
			cia_a_sel_o  <= active && (region_i == RGN_CIA_A);
			cia_b_sel_o  <= active && (region_i == RGN_CIA_B);
			custom_sel_o <= active && (region_i == RGN_CUSTOM);
		end
	end

	// address and write data, held between accesses
	always_ff @(posedge clk) begin
		if (active) begin
			ram_addr_o  <= cpu_addr_i;
			ram_wdata_o <= cpu_wdata_i;
		end
	end

	// bank follows the registered region
	always_comb begin
		case (acc_region_o)
			RGN_SLOW: ram_bank_o = BANK_SLOW;
			RGN_ROM:  ram_bank_o = BANK_ROM;
			default:  ram_bank_o = BANK_CHIP;
		endcase
	end

endmodule

`default_nettype wire

/* design/read_merge.sv */
// read data return path; ors the answering target with the rtc nibble and registers data and dtack
`timescale 1ns/1ps
`default_nettype none

module read_merge import glue_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              acc_valid_i,  // strobe cycle of an access
	input  region_e           acc_region_i,
	input  logic              acc_write_i,
	input  logic [ADDR_W:1]   acc_addr_i,
	input  logic [DATA_W-1:0] mem_rdata_i,    // chip, slow and rom banks
	input  logic [DATA_W-1:0] cia_rdata_i,    // cia b on the high byte, cia a on the low
	input  logic [DATA_W-1:0] custom_rdata_i,
	input  logic [63:0]       rtc_i,          // sixteen bcd nibbles
	output logic [DATA_W-1:0] cpu_rdata_o,
	output logic              cpu_dtack_o
);

	logic              rd;
	logic [3:0]        rtc_nibble;
	logic [DATA_W-1:0] mem_part;
	logic [DATA_W-1:0] cia_part;
	logic [DATA_W-1:0] custom_part;
	logic [DATA_W-1:0] rtc_part;
	logic [DATA_W-1:0] merged;

	// --------------------
	// source gating
	// --------------------
	always_comb begin
		rd         = acc_valid_i && !acc_write_i; // writes read back zero
		rtc_nibble = rtc_i[{acc_addr_i[5:2], 2'b00} +: 4]; // one nibble per long word

		mem_part = '0;
		if (rd && (acc_region_i == RGN_CHIP || acc_region_i == RGN_SLOW ||
			acc_region_i == RGN_ROM))
			mem_part = mem_rdata_i;

		cia_part = '0;
		if (rd && (acc_region_i == RGN_CIA_A || acc_region_i == RGN_CIA_B))
			cia_part = cia_rdata_i;

		custom_part = (rd && acc_region_i == RGN_CUSTOM) ? custom_rdata_i : '0;
		rtc_part    = (rd && acc_region_i == RGN_RTC) ? {{(DATA_W-4){1'b0}}, rtc_nibble} : '0;

		merged = mem_part | cia_part | custom_part | rtc_part; // unmapped leaves zero
	end

	// --------------------
	// return register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset)
			cpu_dtack_o <= 1'b0;
		else
			cpu_dtack_o <= acc_valid_i; // one pulse per access
	end

	always_ff @(posedge clk) begin
		cpu_rdata_o <= merged;
	end

endmodule

`default_nettype wire

/* design/reset_sequencer.sv */
// system reset control; merges reset requests and stretches system reset over a few frames
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer import glue_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rst_ext_i,     // reset from the control block
	input  logic kbd_reset_n_i, // ctrl-amiga-amiga
	input  logic usr_rst_i,     // user reset from the osd
	input  logic cpu_rst_req_i, // host asks to hold only the cpu
	input  logic cpu_reset_n_i, // reset out of the cpu core
	input  logic sof_i,         // start of frame pulse
	output logic sys_reset_o,
	output logic rst_o,         // reset seen by the rest of the machine
	output logic cpu_reset_n_o
);

	logic                   ext_req;
	logic                   hold_q;    // still waiting for frames
	logic [FRAME_CNT_W-1:0] frame_cnt;

	assign ext_req = rst_ext_i || !kbd_reset_n_i || usr_rst_i;

	// --------------------
	// frame counter
	// --------------------
	always_ff @(posedge clk) begin
		if (reset || ext_req) begin
			hold_q    <= 1'b1;
			frame_cnt <= '0; // restart the wait on every request
		end else if (hold_q && sof_i) begin
			if (frame_cnt == FRAME_CNT_W'(RESET_FRAMES - 1))
				hold_q <= 1'b0; // last frame start, release next cycle
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// --------------------
	// reset outputs
	// --------------------
	always_comb begin
		sys_reset_o   = hold_q || ext_req; // high for as long as a request is present
		rst_o         = sys_reset_o || !cpu_reset_n_i;
		cpu_reset_n_o = !(sys_reset_o || cpu_rst_req_i);
	end

endmodule

`default_nettype wire

/* design/feature_control.sv */
// configuration register; derives feature flags, pal/ntsc, power led and the mcu vsync toggle
`timescale 1ns/1ps
`default_nettype none

module feature_control import glue_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rst_i,         // machine reset, lets ntsc change
	input  logic [MEMCFG_W-1:0]  config_mem_i,
	input  logic [CHIPCFG_W-1:0] config_chip_i,
	input  logic [CPUCFG_W-1:0]  config_cpu_i,
	input  logic                 ovl_i,
	input  logic                 led_n_i,       // cia a port bit, low = lit
	input  logic                 led_dim_n_i,   // low = dim the led while off
	input  logic                 hblank_i,
	input  logic                 vsync_n_i,
	output logic [1:0]           chip_size_o,
	output logic [1:0]           slow_size_o,
	output logic                 aga_o,
	output logic                 turbochip_o,
	output logic                 turbokick_o,
	output logic                 ntsc_o,
	output logic                 pwr_led_o,
	output logic                 init_o         // toggles once per frame for the mcu
);

	logic ntsc_sel_q;  // requested mode, takes effect on reset
	logic fast_chip_q;
	logic fast_kick_q;
	logic vsync_n_q;   // for edge detect

	// --------------------
	// configuration
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			chip_size_o <= 2'b00;
			slow_size_o <= 2'b00;
			aga_o       <= 1'b0;
			ntsc_sel_q  <= 1'b0;
			fast_chip_q <= 1'b0;
			fast_kick_q <= 1'b0;
		end else begin
			chip_size_o <= config_mem_i[1:0];
			slow_size_o <= config_mem_i[3:2];
			aga_o       <= config_chip_i[4];
			ntsc_sel_q  <= config_chip_i[1];
			fast_chip_q <= config_cpu_i[2];
			fast_kick_q <= config_cpu_i[3];
		end
	end

	// video standard only switches while the machine is in reset
	always_ff @(posedge clk) begin
		if (reset)
			ntsc_o <= 1'b0; // pal
		else if (rst_i)
			ntsc_o <= ntsc_sel_q;
	end

	// --------------------
	// vsync toggle
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_n_q <= 1'b1;
			init_o    <= 1'b0;
		end else begin
			vsync_n_q <= vsync_n_i;
			if (vsync_n_q && !vsync_n_i)
				init_o <= !init_o; // falling edge of vsync
		end
	end

	// turbo paths only with aga and the rom overlay gone
	always_comb begin
		turbokick_o = aga_o && fast_kick_q && !ovl_i;
		turbochip_o = aga_o && fast_chip_q && !ovl_i && (chip_size_o == 2'b11); // 2 MB chip
		pwr_led_o   = !led_n_i || (!led_dim_n_i && hblank_i); // dim glow during hblank
	end

endmodule

`default_nettype wire

/* design/system_glue.sv */
// top of the system glue; decode, access, read return, reset and feature blocks wired together
`timescale 1ns/1ps
`default_nettype none

module system_glue import glue_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	// cpu bus
	input  logic                 cpu_as_i,
	input  logic                 cpu_rw_i,
	input  logic [ADDR_W:1]      cpu_addr_i,
	input  logic                 cpu_uds_n_i,
	input  logic                 cpu_lds_n_i,
	input  logic [DATA_W-1:0]    cpu_wdata_i,
	output logic [DATA_W-1:0]    cpu_rdata_o,
	output logic                 cpu_dtack_o,
	// memory and peripheral targets
	output logic                 ram_rd_o,
	output logic                 ram_hwr_o,
	output logic                 ram_lwr_o,
	output bank_e                ram_bank_o,
	output logic [ADDR_W:1]      ram_addr_o,
	output logic [DATA_W-1:0]    ram_wdata_o,
	input  logic [DATA_W-1:0]    mem_rdata_i,
	output logic                 cia_a_sel_o,
	output logic                 cia_b_sel_o,
	input  logic [DATA_W-1:0]    cia_rdata_i,
	output logic                 custom_sel_o,
	input  logic [DATA_W-1:0]    custom_rdata_i,
	output logic                 cpu_wr_o,
	input  logic [63:0]          rtc_i,
	// cia port bits
	input  logic                 ovl_i,
	input  logic                 led_n_i,
	// reset sources and lines
	input  logic                 rst_ext_i,
	input  logic                 kbd_reset_n_i,
	input  logic                 usr_rst_i,
	input  logic                 cpu_rst_req_i,
	input  logic                 cpu_reset_n_i,
	input  logic                 sof_i,
	output logic                 sys_reset_o,
	output logic                 rst_o,
	output logic                 cpu_reset_n_o,
	// configuration and flags
	input  logic [MEMCFG_W-1:0]  config_mem_i,
	input  logic [CHIPCFG_W-1:0] config_chip_i,
	input  logic [CPUCFG_W-1:0]  config_cpu_i,
	input  logic                 led_dim_n_i,
	input  logic                 hblank_i,
	input  logic                 vsync_n_i,
	output logic [1:0]           chip_size_o,
	output logic [1:0]           slow_size_o,
	output logic                 aga_o,
	output logic                 turbochip_o,
	output logic                 turbokick_o,
	output logic                 ntsc_o,
	output logic                 pwr_led_o,
	output logic                 init_o
);

	region_e region;     // decoded, same cycle as the strobe
	cycle_e  cycle;
	region_e acc_region; // registered, strobe cycle
	logic    acc_valid;

	// --------------------
	// bus path
	// --------------------
	bus_decode i_bus_decode (
		.cpu_as_i(cpu_as_i), .cpu_rw_i(cpu_rw_i), .cpu_addr_i(cpu_addr_i), .ovl_i(ovl_i),
		.chip_size_i(chip_size_o), .slow_size_i(slow_size_o),
		.region_o(region), .cycle_o(cycle)
	);

	bus_execute i_bus_execute (
		.clk(clk), .reset(reset), .region_i(region), .cycle_i(cycle),
		.cpu_addr_i(cpu_addr_i), .cpu_wdata_i(cpu_wdata_i),
		.cpu_uds_n_i(cpu_uds_n_i), .cpu_lds_n_i(cpu_lds_n_i),
		.ram_rd_o(ram_rd_o), .ram_hwr_o(ram_hwr_o), .ram_lwr_o(ram_lwr_o),
		.ram_bank_o(ram_bank_o), .ram_addr_o(ram_addr_o), .ram_wdata_o(ram_wdata_o),
		.cia_a_sel_o(cia_a_sel_o), .cia_b_sel_o(cia_b_sel_o), .custom_sel_o(custom_sel_o),
		.cpu_wr_o(cpu_wr_o), .acc_region_o(acc_region), .acc_valid_o(acc_valid)
	);

	read_merge i_read_merge (
		.clk(clk), .reset(reset), .acc_valid_i(acc_valid), .acc_region_i(acc_region),
		.acc_write_i(cpu_wr_o), .acc_addr_i(ram_addr_o),
		.mem_rdata_i(mem_rdata_i), .cia_rdata_i(cia_rdata_i),
		.custom_rdata_i(custom_rdata_i), .rtc_i(rtc_i),
		.cpu_rdata_o(cpu_rdata_o), .cpu_dtack_o(cpu_dtack_o)
	);

	// --------------------
	// reset and features
	// --------------------
	reset_sequencer i_reset_sequencer (
		.clk(clk), .reset(reset), .rst_ext_i(rst_ext_i), .kbd_reset_n_i(kbd_reset_n_i),
		.usr_rst_i(usr_rst_i), .cpu_rst_req_i(cpu_rst_req_i), .cpu_reset_n_i(cpu_reset_n_i),
		.sof_i(sof_i), .sys_reset_o(sys_reset_o), .rst_o(rst_o), .cpu_reset_n_o(cpu_reset_n_o)
	);

	feature_control i_feature_control (
		.clk(clk), .reset(reset), .rst_i(rst_o),
		.config_mem_i(config_mem_i), .config_chip_i(config_chip_i), .config_cpu_i(config_cpu_i),
		.ovl_i(ovl_i), .led_n_i(led_n_i), .led_dim_n_i(led_dim_n_i),
		.hblank_i(hblank_i), .vsync_n_i(vsync_n_i),
		.chip_size_o(chip_size_o), .slow_size_o(slow_size_o), .aga_o(aga_o),
		.turbochip_o(turbochip_o), .turbokick_o(turbokick_o), .ntsc_o(ntsc_o),
		.pwr_led_o(pwr_led_o), .init_o(init_o)
	);

endmodule

`default_nettype wire

/* bench/glue_ref.svh */
// reference model for the glue testbench; expected region, bank, read data and flags from the address map
`ifndef GLUE_REF_SVH
`define GLUE_REF_SVH

	localparam logic [15:0] CIA_PAT    = 16'hc1a5; // fixed cia answer
	localparam logic [15:0] CUSTOM_PAT = 16'hdf0f;

	// target of one access, overlay only bends low reads
	function automatic region_e ref_region(input logic [ADDR_W:1] a, input logic rd,
		input logic ovl, input logic [1:0] chip_sz, input logic [1:0] slow_sz);
		int unsigned w;
		w = 32'(a);
		if (w >= ROM_BASE && w - ROM_BASE < RAM_BLOCK_WORDS)
			return RGN_ROM;
		if (w >= CHIP_BASE && w - CHIP_BASE < (int'(chip_sz) + 1) * RAM_BLOCK_WORDS)
			return (ovl && rd && w < OVL_LIMIT) ? RGN_ROM : RGN_CHIP;
		if (slow_sz != 2'b00 && w >= SLOW_BASE && w - SLOW_BASE < int'(slow_sz) * RAM_BLOCK_WORDS)
			return RGN_SLOW;
		if (w >= CIA_BASE && w - CIA_BASE < PAGE_WORDS)
			return !a[12] ? RGN_CIA_A : (!a[13] ? RGN_CIA_B : RGN_NONE);
		if (w >= CUSTOM_BASE && w - CUSTOM_BASE < PAGE_WORDS)
			return RGN_CUSTOM;
		if (w >= RTC_BASE && w - RTC_BASE < PAGE_WORDS)
			return RGN_RTC;
		return RGN_NONE;
	endfunction

	function automatic bank_e ref_bank(input region_e r);
		if (r == RGN_SLOW) return BANK_SLOW;
		if (r == RGN_ROM)  return BANK_ROM;
		return BANK_CHIP;
	endfunction

	// memory model, one pattern per bank
	function automatic logic [15:0] bank_pattern(input bank_e b);
		case (b)
			BANK_SLOW: return 16'h5107;
			BANK_ROM:  return 16'hb00f;
			default:   return 16'hc41f;
		endcase
	endfunction

	// {ram_rd, hwr, lwr, cia_a, cia_b, custom}
	function automatic logic [5:0] ref_strobes(input region_e r, input logic rd,
		input logic uds_n, input logic lds_n);
		logic mem;
		mem = (r == RGN_CHIP || r == RGN_SLOW);
		return {rd && (mem || r == RGN_ROM), !rd && mem && !uds_n, !rd && mem && !lds_n,
			r == RGN_CIA_A, r == RGN_CIA_B, r == RGN_CUSTOM};
	endfunction

	function automatic logic [15:0] ref_rdata(input region_e r, input logic rd,
		input logic [ADDR_W:1] a, input logic [63:0] rtc);
		if (!rd) return 16'h0000; // writes come back zero
		case (r)
			RGN_CHIP, RGN_SLOW, RGN_ROM: return bank_pattern(ref_bank(r));
			RGN_CIA_A, RGN_CIA_B:        return CIA_PAT;
			RGN_CUSTOM:                  return CUSTOM_PAT;
			RGN_RTC:                     return {12'h000, rtc[4 * int'(a[5:2]) +: 4]};
			default:                     return 16'h0000;
		endcase
	endfunction

	// {aga, turbochip, turbokick}
	function automatic logic [2:0] ref_flags(input logic [4:0] chip, input logic [3:0] cpu,
		input logic [6:0] mem, input logic ovl);
		return {chip[4], chip[4] && cpu[2] && !ovl && mem[1:0] == 2'b11, chip[4] && cpu[3] && !ovl};
	endfunction

	function automatic logic ref_led(input logic led_n, input logic dim_n, input logic hblank);
		return dim_n ? !led_n : (!led_n || hblank);
	endfunction

`endif

/* bench/tb_system_glue.sv */
// testbench for the system glue; random bus accesses, reset sequencing and feature flags
`timescale 1ns/1ps
`default_nettype none

module tb_system_glue import glue_pkg::*;;

	`include "glue_ref.svh"

	logic clk, reset;
	logic cpu_as_i, cpu_rw_i, cpu_uds_n_i, cpu_lds_n_i, cpu_dtack_o, cpu_wr_o;
	logic [ADDR_W:1] cpu_addr_i, ram_addr_o;
	logic [DATA_W-1:0] cpu_wdata_i, cpu_rdata_o, ram_wdata_o;
	logic [DATA_W-1:0] mem_rdata_i, cia_rdata_i, custom_rdata_i;
	logic ram_rd_o, ram_hwr_o, ram_lwr_o, cia_a_sel_o, cia_b_sel_o, custom_sel_o;
	bank_e ram_bank_o;
	logic [63:0] rtc_i;
	logic ovl_i, led_n_i, led_dim_n_i, hblank_i, vsync_n_i;
	logic rst_ext_i, kbd_reset_n_i, usr_rst_i, cpu_rst_req_i, cpu_reset_n_i, sof_i;
	logic sys_reset_o, rst_o, cpu_reset_n_o;
	logic [MEMCFG_W-1:0] config_mem_i;
	logic [CHIPCFG_W-1:0] config_chip_i;
	logic [CPUCFG_W-1:0] config_cpu_i;
	logic [1:0] chip_size_o, slow_size_o;
	logic aga_o, turbochip_o, turbokick_o, ntsc_o, pwr_led_o, init_o;

	integer seed = 99828;
	int unsigned cyc = 0; // posedge count
	int errors = 0;
	int checks = 0;
	logic exp_init = 1'b0;
	logic prev_ntsc;
	logic [ADDR_W:1] addr;

	// expected strobes and answers, stamped with the strobe cycle
	int unsigned str_cyc[$];
	logic [5:0] str_vec[$];
	bank_e str_bank[$];
	logic [ADDR_W:1] str_addr[$];
	logic [DATA_W-1:0] str_wdata[$];
	logic str_wr[$]; // registered access is a write
	int unsigned rd_cyc[$];
	logic [DATA_W-1:0] rd_data[$];

	system_glue i_system_glue (.*);

	// external targets answer in the strobe cycle
	assign mem_rdata_i    = bank_pattern(ram_bank_o);
	assign cia_rdata_i    = CIA_PAT;
	assign custom_rdata_i = CUSTOM_PAT;

	always #20 clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("** Error %0t: %s", $time, msg);
		end
	endtask

	// --------------------
	// bus stimulus
	// --------------------
	task automatic access(input logic [ADDR_W:1] a, input logic rd, input logic [1:0] be_n);
		region_e r;
		@(negedge clk);
		r = ref_region(a, rd, ovl_i, config_mem_i[1:0], config_mem_i[3:2]);
		cpu_as_i = 1'b1;
		cpu_addr_i = a;
		cpu_rw_i = rd;
		{cpu_uds_n_i, cpu_lds_n_i} = be_n;
		cpu_wdata_i = DATA_W'($random(seed));
		str_cyc.push_back(cyc);
		str_vec.push_back(ref_strobes(r, rd, be_n[1], be_n[0]));
		str_bank.push_back(ref_bank(r));
		str_addr.push_back(a);
		str_wdata.push_back(cpu_wdata_i);
		str_wr.push_back(!rd);
		rd_cyc.push_back(cyc);
		rd_data.push_back(ref_rdata(r, rd, a, rtc_i));
	endtask

	task automatic idle();
		@(negedge clk);
		cpu_as_i = 1'b0;
	endtask

	// random address aimed at one of the map regions
	task automatic pick_addr(output logic [ADDR_W:1] a);
		int unsigned off;
		off = $random(seed);
		case ($unsigned($random(seed)) % 7)
			0: a = ADDR_W'(CHIP_BASE + (off & 32'h000f_ffff));
			1: a = ADDR_W'(SLOW_BASE + (off & 32'h000f_ffff)); // runs into custom space too
			2: a = ADDR_W'(ROM_BASE + (off & 32'h0003_ffff));
			3: a = ADDR_W'(CIA_BASE + (off & 32'h0000_7fff));
			4: a = ADDR_W'(CUSTOM_BASE + (off & 32'h0000_7fff));
			5: a = ADDR_W'(RTC_BASE + (off & 32'h0000_7fff));
			default: a = ADDR_W'(off);
		endcase
	endtask

	task automatic drain();
		int t;
		t = 0;
		while ((str_cyc.size() > 0 || rd_cyc.size() > 0) && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (str_cyc.size() > 0 || rd_cyc.size() > 0) begin
			errors++;
			$display("timeout: accesses never got their strobe or dtack");
		end
	endtask

	// frame starts until system reset lets go
	task automatic release_reset();
		int t;
		t = 0;
		while (sys_reset_o && t < 100) begin
			@(negedge clk) sof_i = (t % 3 == 0);
			t++;
		end
		@(negedge clk) sof_i = 1'b0;
		if (sys_reset_o) begin
			errors++;
			$display("timeout: system reset never released");
		end
	endtask

	// --------------------
	// compare process
	// --------------------
	always @(negedge clk) begin : compare
		logic [5:0] vec;
		logic due, exp_d;
		vec = '0;
		due = 1'b0;
		exp_d = 1'b0;
		if (!reset) begin
			if (str_cyc.size() > 0 && str_cyc[0] + 1 == cyc) begin
				due = 1'b1;
				vec = str_vec[0];
			end
			check({ram_rd_o, ram_hwr_o, ram_lwr_o, cia_a_sel_o, cia_b_sel_o, custom_sel_o} == vec,
				$sformatf("strobes %b, expected %b", {ram_rd_o, ram_hwr_o, ram_lwr_o,
				cia_a_sel_o, cia_b_sel_o, custom_sel_o}, vec));
			if (due && vec[5:3] != 3'b000)
				check(ram_bank_o == str_bank[0] && ram_addr_o == str_addr[0],
					$sformatf("bank %0d addr %h, expected %0d %h", ram_bank_o, ram_addr_o,
					str_bank[0], str_addr[0]));
			if (due && vec[4:3] != 2'b00)
				check(ram_wdata_o == str_wdata[0], $sformatf("write data %h", ram_wdata_o));
			if (due) begin
				check(cpu_wr_o == str_wr[0],
					$sformatf("cpu_wr %b, expected %b", cpu_wr_o, str_wr[0]));
				void'(str_cyc.pop_front());
				void'(str_vec.pop_front());
				void'(str_bank.pop_front());
				void'(str_addr.pop_front());
				void'(str_wdata.pop_front());
				void'(str_wr.pop_front());
			end
			exp_d = rd_cyc.size() > 0 && rd_cyc[0] + 2 == cyc; // two cycles after the strobe
			check(cpu_dtack_o == exp_d, $sformatf("dtack %b, expected %b", cpu_dtack_o, exp_d));
			if (exp_d) begin
				check(cpu_rdata_o == rd_data[0],
					$sformatf("read data %h, expected %h", cpu_rdata_o, rd_data[0]));
				void'(rd_cyc.pop_front());
				void'(rd_data.pop_front());
			end
		end
	end

	// --------------------
	// test sequence
	// --------------------
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		{cpu_as_i, cpu_rw_i, cpu_addr_i, cpu_wdata_i} = '0;
		{cpu_uds_n_i, cpu_lds_n_i} = 2'b11;
		rtc_i = {$random(seed), $random(seed)};
		{ovl_i, hblank_i, rst_ext_i, usr_rst_i, cpu_rst_req_i, sof_i} = '0;
		{led_n_i, led_dim_n_i, vsync_n_i, kbd_reset_n_i, cpu_reset_n_i} = '1;
		{config_mem_i, config_chip_i, config_cpu_i} = '0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		check(!cpu_dtack_o && !ram_rd_o && !init_o && sys_reset_o && !cpu_reset_n_o,
			"outputs not in their reset state");
		release_reset();

		// random reads, back to back with random gaps
		repeat (4) begin
			@(negedge clk) config_mem_i = MEMCFG_W'($random(seed) & 4'hf);
			@(negedge clk);
			repeat (50) begin
				pick_addr(addr);
				access(addr, 1'b1, 2'b00);
				if ($random(seed) % 4 == 0)
					idle();
			end
			idle();
			drain();
		end

		// overlay window at address 0
		@(negedge clk) ovl_i = 1'b1;
		repeat (30)
			access(ADDR_W'($random(seed)) & ADDR_W'(OVL_LIMIT - 1), 1'($random(seed)), 2'b00);
		idle();
		drain();
		ovl_i = 1'b0;

		// mixed reads and writes with random byte strobes
		repeat (80) begin
			pick_addr(addr);
			access(addr, 1'($random(seed)), 2'($random(seed)));
		end
		idle();
		drain();

		// reset sequencing
		@(negedge clk) rst_ext_i = 1'b1;
		@(negedge clk) rst_ext_i = 1'b0;
		check(sys_reset_o && !cpu_reset_n_o && rst_o, "reset request not seen");
		for (int k = 1; k <= RESET_FRAMES; k++) begin
			@(negedge clk) sof_i = 1'b1;
			@(negedge clk) sof_i = 1'b0;
			check(sys_reset_o == (k < RESET_FRAMES), $sformatf("sys_reset after frame %0d", k));
			check(cpu_reset_n_o == !(k < RESET_FRAMES), "cpu reset does not follow system reset");
		end
		@(negedge clk) cpu_rst_req_i = 1'b1;
		@(negedge clk) check(!cpu_reset_n_o && !sys_reset_o, "cpu reset request");
		cpu_rst_req_i = 1'b0;
		cpu_reset_n_i = 1'b0;
		@(negedge clk) check(rst_o && cpu_reset_n_o, "rst_o does not follow the cpu reset");
		cpu_reset_n_i = 1'b1;
		kbd_reset_n_i = 1'b0;
		@(negedge clk) kbd_reset_n_i = 1'b1;
		check(sys_reset_o, "keyboard reset not seen");
		release_reset();

		// feature flags, ntsc held outside reset
		repeat (30) begin
			@(negedge clk);
			prev_ntsc = ntsc_o;
			config_mem_i = MEMCFG_W'($random(seed));
			config_chip_i = CHIPCFG_W'($random(seed));
			config_cpu_i = CPUCFG_W'($random(seed));
			{ovl_i, led_n_i, led_dim_n_i, hblank_i} = 4'($random(seed));
			@(negedge clk);
			check({aga_o, turbochip_o, turbokick_o} ==
				ref_flags(config_chip_i, config_cpu_i, config_mem_i, ovl_i), "feature flags");
			check(pwr_led_o == ref_led(led_n_i, led_dim_n_i, hblank_i), "power led");
			check(chip_size_o == config_mem_i[1:0] && slow_size_o == config_mem_i[3:2], "sizes");
			@(negedge clk); // new ntsc request has been registered a full cycle
			check(ntsc_o == prev_ntsc, "ntsc changed outside reset");
		end
		config_chip_i[1] = !ntsc_o; // make the reload visible
		@(negedge clk) usr_rst_i = 1'b1;
		@(negedge clk) usr_rst_i = 1'b0;
		check(ntsc_o == config_chip_i[1], "ntsc not loaded during reset");
		release_reset();
		ovl_i = 1'b0;

		// vsync toggle for the mcu
		repeat (5) begin
			@(negedge clk) vsync_n_i = 1'b0;
			exp_init = !exp_init;
			repeat (3) @(negedge clk) check(init_o == exp_init, "init toggle");
			vsync_n_i = 1'b1;
			repeat (3) @(negedge clk) check(init_o == exp_init, "init toggle");
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// guard against a stuck run
	initial begin
		#2_000_000;
		$display("simulation did not finish in time");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+bench
design/glue_pkg.sv
design/bus_decode.sv
design/bus_execute.sv
design/read_merge.sv
design/reset_sequencer.sv
design/feature_control.sv
design/system_glue.sv
bench/tb_system_glue.sv

/* Makefile */
# Verilator build and run of the system glue testbench

VERILATOR ?= verilator
TOP       ?= tb_system_glue
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Checks failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "All checks passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
